//--- src/memBusPkg.sv
package memBusPkg;

   ////////////////////////////////////////////////////////////////////////
   // Bus word layout
   ////////////////////////////////////////////////////////////////////////

   // Address and data words, bit 0 is the MSB
   localparam int unsigned busWidth = 36;

   // Flag bits in the address word
   localparam int unsigned flagRead   = 3;
   localparam int unsigned flagWrTest = 4;
   localparam int unsigned flagWrite  = 5;
   localparam int unsigned flagIo     = 10;

   // IO device number field
   localparam int unsigned devMsb = 14;
   localparam int unsigned devLsb = 17;

   // Word address field, 20 bits
   localparam int unsigned addrMsb = 16;
   localparam int unsigned addrLsb = 35;

   ////////////////////////////////////////////////////////////////////////
   // Memory size
   ////////////////////////////////////////////////////////////////////////

   // Only 32K words are present
   localparam int unsigned ramAddrWidth = 15;
   localparam int unsigned ramWords     = 32768;

   ////////////////////////////////////////////////////////////////////////
   // Bus operations
   ////////////////////////////////////////////////////////////////////////

   // Decoded operation of one accepted request
   typedef enum logic [2:0]
   {
      opRead,
      opWrite,
      opWrTest,
      opStatRead,
      opStatWrite
   } memOp_t;

endpackage

//--- src/memStatPkg.sv
package memStatPkg;

   ////////////////////////////////////////////////////////////////////////
   // Memory status register location
   ////////////////////////////////////////////////////////////////////////

   // IO address 100000 octal on device 0
   localparam logic [19:0] statIoAddr = 20'o100000;
   localparam logic [3:0]  statDev    = 4'd0;

   ////////////////////////////////////////////////////////////////////////
   // Bit positions
   ////////////////////////////////////////////////////////////////////////

   // Parity error, read and write
   localparam int unsigned bitPe = 3;

   // ECC enable, read only
   localparam int unsigned bitEe = 4;

   // Power failure, write zero to clear
   localparam int unsigned bitPf = 12;

   // ECC disable, write only, sets EE inverted
   localparam int unsigned bitEd = 35;

   ////////////////////////////////////////////////////////////////////////
   // Reset values
   ////////////////////////////////////////////////////////////////////////

   // PF set at power up, ECC enabled
   localparam logic resetPe = 1'b0;
   localparam logic resetEe = 1'b1;
   localparam logic resetPf = 1'b1;

endpackage

//--- src/memBusDecode.sv
`timescale 1ns/1ps

module memBusDecode
(
   input  logic                 busReq,
   input  logic [0:35]          busAddr,
   output logic                 reqAccept,
   output memBusPkg::memOp_t    reqOp,
   output logic [14:0]          reqRamAddr,
   output logic                 reqHighAddr
);

   // Flags from the address word
   logic isRead;
   logic isWrTest;
   logic isWrite;
   logic isIo;

   // Device and word address fields
   logic [0:3]  devField;
   logic [19:0] wordAddr;

   // Status register selected
   logic statHit;

   // Request qualifies before busReq is applied
   logic opValid;

   assign isRead   = busAddr[memBusPkg::flagRead];
   assign isWrTest = busAddr[memBusPkg::flagWrTest];
   assign isWrite  = busAddr[memBusPkg::flagWrite];
   assign isIo     = busAddr[memBusPkg::flagIo];

   assign devField = busAddr[memBusPkg::devMsb:memBusPkg::devLsb];
   assign wordAddr = busAddr[memBusPkg::addrMsb:memBusPkg::addrLsb];

   // Device 0 at IO address 100000
   assign statHit = (devField == memStatPkg::statDev) &&
                    (wordAddr == memStatPkg::statIoAddr);

   // Only comparison against memory size
   assign reqHighAddr = (wordAddr >= 20'(memBusPkg::ramWords));

   // Low bits index the RAM
   assign reqRamAddr = wordAddr[memBusPkg::ramAddrWidth-1:0];

   ////////////////////////////////////////////////////////////////////////
   // Operation select
   ////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      reqOp   = memBusPkg::opRead;
      opValid = 1'b0;
      if (isIo)
      begin
         // Other IO devices see nothing here
         if (statHit && isWrite)
         begin
            reqOp   = memBusPkg::opStatWrite;
            opValid = 1'b1;
         end
         else if (statHit && isRead)
         begin
            reqOp   = memBusPkg::opStatRead;
            opValid = 1'b1;
         end
      end
      else if (isWrite)
      begin
         // Any address, high ones never reach the RAM
         reqOp   = memBusPkg::opWrite;
         opValid = 1'b1;
      end
      else if (isWrTest)
      begin
         reqOp   = memBusPkg::opWrTest;
         opValid = 1'b1;
      end
      else if (isRead && !reqHighAddr)
      begin
         // Reads above 32K give no ack, i.e. NXM
         reqOp   = memBusPkg::opRead;
         opValid = 1'b1;
      end
   end

   assign reqAccept = busReq && opValid;

endmodule

//--- src/memStatusReg.sv
`timescale 1ns/1ps

module memStatusReg
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clken,
   input  logic        statWe,
   input  logic [0:35] statWData,
   output logic [0:35] statWord
);

   // Only implemented status bits
   logic pe;
   logic ee;
   logic pf;

   ////////////////////////////////////////////////////////////////////////
   // Status bits
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pe <= memStatPkg::resetPe;
         ee <= memStatPkg::resetEe;
         pf <= memStatPkg::resetPf;
      end
      else if (clken && statWe)
      begin
         // PE written directly
         pe <= statWData[memStatPkg::bitPe];
         // EE is the inverse of ED
         ee <= ~statWData[memStatPkg::bitEd];
         // Zero clears PF, one leaves it alone
         pf <= statWData[memStatPkg::bitPf] & pf;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Read word
   ////////////////////////////////////////////////////////////////////////

   // EH, UE, RE, ECP, FCB and ERA read as zero
   always_comb
   begin
      statWord = '0;
      statWord[memStatPkg::bitPe] = pe;
      statWord[memStatPkg::bitEe] = ee;
      statWord[memStatPkg::bitPf] = pf;
   end

endmodule

//--- src/memArray.sv
`timescale 1ns/1ps

module memArray
(
   input  logic        clk,
   input  logic        clken,
   input  logic        ramWe,
   input  logic [14:0] ramAddr,
   input  logic [0:35] ramWData,
   output logic [0:35] ramRData
);

   // 32K words of storage, contents undefined at power up
   logic [0:memBusPkg::busWidth-1] memCells [0:memBusPkg::ramWords-1];

   // Single port, read before write
   always_ff @(posedge clk)
   begin
      if (clken)
      begin
         if (ramWe)
         begin
            memCells[ramAddr] <= ramWData;
         end
         // Old contents on a write cycle
         ramRData <= memCells[ramAddr];
      end
   end

endmodule

//--- src/memAccessPipe.sv
`timescale 1ns/1ps

module memAccessPipe
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 clken,
   input  logic                 reqAccept,
   input  memBusPkg::memOp_t    reqOp,
   input  logic [14:0]          reqRamAddr,
   input  logic                 reqHighAddr,
   input  logic [0:35]          busDataIn,
   input  logic [0:35]          ramRData,
   input  logic [0:35]          statWord,
   output logic                 ramWe,
   output logic [14:0]          ramAddr,
   output logic [0:35]          ramWData,
   output logic                 statWe,
   output logic [0:35]          statWData,
   output logic                 busAck,
   output logic [0:35]          busDataOut
);

   // Stage 1, request issued to RAM and status register
   logic              s1Valid;
   memBusPkg::memOp_t s1Op;
   logic [0:35]       s1Data;

   // Tag that runs beside the RAM read register
   logic              tagValid;
   memBusPkg::memOp_t tagOp;
   logic [0:35]       tagData;

   // Return data before the output register
   logic [0:35]       ackData;

   ////////////////////////////////////////////////////////////////////////
   // Stage 1
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         s1Valid <= 1'b0;
         ramWe   <= 1'b0;
         statWe  <= 1'b0;
      end
      else if (clken)
      begin
         s1Valid <= reqAccept;
         // Writes above 32K are acked but dropped
         ramWe   <= reqAccept && (reqOp == memBusPkg::opWrite) && !reqHighAddr;
         statWe  <= reqAccept && (reqOp == memBusPkg::opStatWrite);
      end
   end

   always_ff @(posedge clk)
   begin
      if (clken)
      begin
         s1Op    <= reqOp;
         ramAddr <= reqRamAddr;
         s1Data  <= busDataIn;
      end
   end

   // Same write data to both targets
   assign ramWData  = s1Data;
   assign statWData = s1Data;

   // Aligned with ramRData
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         tagValid <= 1'b0;
      end
      else if (clken)
      begin
         tagValid <= s1Valid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (clken)
      begin
         tagOp   <= s1Op;
         tagData <= s1Data;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Stage 2
   ////////////////////////////////////////////////////////////////////////

   // Status word already holds any write from stage 1
   always_comb
   begin
      case (tagOp)
         memBusPkg::opStatRead: ackData = statWord;
         memBusPkg::opRead,
         memBusPkg::opWrTest:   ackData = ramRData;
         default:               ackData = tagData;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busAck <= 1'b0;
      end
      else if (clken)
      begin
         busAck <= tagValid;
      end
   end

   always_ff @(posedge clk)
   begin
      if (clken)
      begin
         busDataOut <= ackData;
      end
   end

endmodule

//--- src/mem.sv
`timescale 1ns/1ps

module mem
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clken,
   input  logic        busReq,
   input  logic [0:35] busAddr,
   input  logic [0:35] busDataIn,
   output logic        busAck,
   output logic [0:35] busDataOut
);

   // Decoded request
   logic              reqAccept;
   memBusPkg::memOp_t reqOp;
   logic [14:0]       reqRamAddr;
   logic              reqHighAddr;

   // RAM port
   logic              ramWe;
   logic [14:0]       ramAddr;
   logic [0:35]       ramWData;
   logic [0:35]       ramRData;

   // Status register port
   logic              statWe;
   logic [0:35]       statWData;
   logic [0:35]       statWord;

   ////////////////////////////////////////////////////////////////////////
   // Request decode and pipeline
   ////////////////////////////////////////////////////////////////////////

   memBusDecode busDecodeInst
   (
      .busReq      (busReq),
      .busAddr     (busAddr),
      .reqAccept   (reqAccept),
      .reqOp       (reqOp),
      .reqRamAddr  (reqRamAddr),
      .reqHighAddr (reqHighAddr)
   );

   memAccessPipe accessPipeInst
   (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .reqAccept   (reqAccept),
      .reqOp       (reqOp),
      .reqRamAddr  (reqRamAddr),
      .reqHighAddr (reqHighAddr),
      .busDataIn   (busDataIn),
      .ramRData    (ramRData),
      .statWord    (statWord),
      .ramWe       (ramWe),
      .ramAddr     (ramAddr),
      .ramWData    (ramWData),
      .statWe      (statWe),
      .statWData   (statWData),
      .busAck      (busAck),
      .busDataOut  (busDataOut)
   );

   ////////////////////////////////////////////////////////////////////////
   // Targets
   ////////////////////////////////////////////////////////////////////////

   memStatusReg statusRegInst
   (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .statWe    (statWe),
      .statWData (statWData),
      .statWord  (statWord)
   );

   memArray arrayInst
   (
      .clk      (clk),
      .clken    (clken),
      .ramWe    (ramWe),
      .ramAddr  (ramAddr),
      .ramWData (ramWData),
      .ramRData (ramRData)
   );

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock
#(
   parameter int period = 20
)
(
   output logic clk
);

   // Free running, starts low
   initial
   begin
      clk = 1'b0;
   end

   always
   begin
      #(period / 2) clk = ~clk;
   end

endmodule

//--- dv/memTb.sv
`timescale 1ns/1ps

module memTb;

   // Requests issued by all behaviors, 1 + 6 + 100 + 7 + 300 + 2
   localparam int totalReqs = 416;

   logic        clk;
   logic        rst;
   logic        clken;
   logic        busReq;
   logic [0:35] busAddr;
   logic [0:35] busDataIn;
   logic        busAck;
   logic [0:35] busDataOut;

   // Shadow memory and status bits
   logic [0:35] shadowMem [int];
   logic        refPe;
   logic        refEe;
   logic        refPf;

   // Expected acknowledges in request order
   memBusPkg::memOp_t expOp [$];
   logic [0:35]       expData [$];
   int                expCycle [$];

   int   enCount = 0;
   logic lastEn = 1'b0;
   int   errors = 0;
   logic randEn = 1'b0;
   int   pool [$];

   tbClock #(.period(20)) clockInst (.clk(clk));

   mem mem_inst
   (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .busReq     (busReq),
      .busAddr    (busAddr),
      .busDataIn  (busDataIn),
      .busAck     (busAck),
      .busDataOut (busDataOut)
   );

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   function automatic logic [0:35] statusWord();
      logic [0:35] w;
      w = '0;
      w[memStatPkg::bitPe] = refPe;
      w[memStatPkg::bitEe] = refEe;
      w[memStatPkg::bitPf] = refPf;
      return w;
   endfunction

   // Returns 1 when the request gets an acknowledge
   function automatic logic refAccess(input logic [0:35] a, input logic [0:35] d,
                                      output memBusPkg::memOp_t op, output logic [0:35] data);
      logic [0:3]  dev;
      logic [19:0] wa;
      logic        hit;
      int          idx;
      dev  = a[memBusPkg::devMsb:memBusPkg::devLsb];
      wa   = a[memBusPkg::addrMsb:memBusPkg::addrLsb];
      idx  = int'(wa[14:0]);
      op   = memBusPkg::opRead;
      data = '0;
      if (a[memBusPkg::flagIo])
      begin
         hit = (dev == memStatPkg::statDev) && (wa == memStatPkg::statIoAddr);
         if (hit && a[memBusPkg::flagWrite])
         begin
            op    = memBusPkg::opStatWrite;
            data  = d;
            refPe = d[memStatPkg::bitPe];
            refEe = ~d[memStatPkg::bitEd];
            refPf = refPf & d[memStatPkg::bitPf];
            return 1'b1;
         end
         if (hit && a[memBusPkg::flagRead])
         begin
            op   = memBusPkg::opStatRead;
            data = statusWord();
            return 1'b1;
         end
         return 1'b0;
      end
      if (a[memBusPkg::flagWrite])
      begin
         // Data echoed back and high addresses store nothing
         op   = memBusPkg::opWrite;
         data = d;
         if (wa < 20'(memBusPkg::ramWords))
         begin
            shadowMem[idx] = d;
         end
         return 1'b1;
      end
      if (a[memBusPkg::flagWrTest])
      begin
         op   = memBusPkg::opWrTest;
         data = shadowMem[idx];
         return 1'b1;
      end
      if (a[memBusPkg::flagRead] && (wa < 20'(memBusPkg::ramWords)))
      begin
         data = shadowMem[idx];
         return 1'b1;
      end
      return 1'b0;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Compare
   //////////////////////////////////////////////////////////////////////

   task automatic checkAck(input logic expected, input logic got);
      if (expected !== got)
      begin
         errors++;
         if (expected)
            $display("Missing acknowledge in enabled cycle %0d", enCount);
         else
            $display("Unexpected acknowledge in enabled cycle %0d", enCount);
      end
   endtask

   task automatic checkData(input memBusPkg::memOp_t op, input logic [0:35] expected,
                            input logic [0:35] got);
      if (got !== expected)
      begin
         errors++;
         $display("[ERROR] busDataOut op %s expected %h got %h", op.name(), expected, got);
      end
   endtask

   // Counts enabled cycles outside reset
   always @(posedge clk)
   begin
      lastEn <= clken && !rst;
      if (clken && !rst)
         enCount <= enCount + 1;
   end

   always @(negedge clk)
   begin
      logic due;
      if (lastEn)
      begin
         due = (expCycle.size() > 0) && (expCycle[0] <= enCount);
         checkAck(due, busAck);
         if (due)
         begin
            if (busAck)
               checkData(expOp[0], expData[0], busDataOut);
            void'(expCycle.pop_front());
            void'(expOp.pop_front());
            void'(expData.pop_front());
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [0:35] randWord();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[35:0];
   endfunction

   function automatic logic [0:35] memWord(input int unsigned flag, input logic [19:0] addr);
      logic [0:35] a;
      a = '0;
      a[flag] = 1'b1;
      a[memBusPkg::addrMsb:memBusPkg::addrLsb] = addr;
      return a;
   endfunction

   // Address field overlaps the low device bits
   function automatic logic [0:35] ioWord(input int unsigned flag, input logic [3:0] dev,
                                          input logic [19:0] addr);
      logic [0:35] a;
      a = '0;
      a[memBusPkg::flagIo] = 1'b1;
      a[flag] = 1'b1;
      a[memBusPkg::devMsb:memBusPkg::devLsb] = dev;
      a[memBusPkg::addrMsb:memBusPkg::addrLsb] = addr;
      return a;
   endfunction

   // Request goes out on the first enabled cycle
   task automatic issue(input logic [0:35] a, input logic [0:35] d);
      memBusPkg::memOp_t op;
      logic [0:35]       data;
      logic              done;
      done = 1'b0;
      while (!done)
      begin
         @(negedge clk);
         clken = randEn ? 1'($urandom() % 2) : 1'b1;
         busReq = clken;
         if (clken)
         begin
            busAddr   = a;
            busDataIn = d;
            if (refAccess(a, d, op, data))
            begin
               expCycle.push_back(enCount + 3);
               expOp.push_back(op);
               expData.push_back(data);
            end
            done = 1'b1;
         end
      end
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(negedge clk);
         busReq = 1'b0;
         clken  = 1'b1;
      end
   endtask

   task automatic drain();
      while (expCycle.size() > 0)
         idle(1);
      idle(4);
   endtask

   // Reset lands while an acknowledge is still in flight
   task automatic resetPulse();
      @(negedge clk);
      rst    = 1'b1;
      busReq = 1'b0;
      expCycle.delete();
      expOp.delete();
      expData.delete();
      refPe = memStatPkg::resetPe;
      refEe = memStatPkg::resetEe;
      refPf = memStatPkg::resetPf;
      @(negedge clk);
      checkAck(1'b0, busAck);
      @(negedge clk);
      rst = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [0:35] d;
      int          addr;
      void'($urandom(14161));
      rst       = 1'b1;
      clken     = 1'b1;
      busReq    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
      refPe     = memStatPkg::resetPe;
      refEe     = memStatPkg::resetEe;
      refPf     = memStatPkg::resetPf;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Status after reset
      issue(ioWord(memBusPkg::flagRead, 4'd0, memStatPkg::statIoAddr), '0);

      // Status writes where PF only clears
      d = randWord();
      d[memStatPkg::bitPe] = 1'b1;
      d[memStatPkg::bitEd] = 1'b0;
      d[memStatPkg::bitPf] = 1'b1;
      issue(ioWord(memBusPkg::flagWrite, 4'd0, memStatPkg::statIoAddr), d);
      issue(ioWord(memBusPkg::flagRead, 4'd0, memStatPkg::statIoAddr), '0);
      d = randWord();
      d[memStatPkg::bitPe] = 1'b0;
      d[memStatPkg::bitEd] = 1'b1;
      d[memStatPkg::bitPf] = 1'b0;
      issue(ioWord(memBusPkg::flagWrite, 4'd0, memStatPkg::statIoAddr), d);
      issue(ioWord(memBusPkg::flagRead, 4'd0, memStatPkg::statIoAddr), '0);
      d[memStatPkg::bitPf] = 1'b1;
      issue(ioWord(memBusPkg::flagWrite, 4'd0, memStatPkg::statIoAddr), d);
      issue(ioWord(memBusPkg::flagRead, 4'd0, memStatPkg::statIoAddr), '0);

      // Memory write, read back, write-test
      for (int i = 0; i < 40; i++)
      begin
         addr = int'($urandom() % memBusPkg::ramWords);
         pool.push_back(addr);
         issue(memWord(memBusPkg::flagWrite, 20'(addr)), randWord());
      end
      foreach (pool[i])
         issue(memWord(memBusPkg::flagRead, 20'(pool[i])), '0);
      for (int i = 0; i < 10; i++)
      begin
         issue(memWord(memBusPkg::flagWrTest, 20'(pool[i])), randWord());
         issue(memWord(memBusPkg::flagRead, 20'(pool[i])), '0);
      end

      // Silent accesses, then a dropped high write
      issue(memWord(memBusPkg::flagRead, 20'(32768 + $urandom() % 1015808)), '0);
      issue(ioWord(memBusPkg::flagRead, 4'd5, 20'o200), '0);
      issue(ioWord(memBusPkg::flagRead, 4'd0, 20'o100001), '0);
      issue(ioWord(0, 4'd0, memStatPkg::statIoAddr), '0);
      issue(memWord(0, 20'(pool[0])), '0);
      issue(memWord(memBusPkg::flagWrite, 20'(32768 + pool[0])), randWord());
      issue(memWord(memBusPkg::flagRead, 20'(pool[0])), '0);
      drain();

      // Back-to-back random traffic with clken toggling
      randEn = 1'b1;
      repeat (300)
      begin
         addr = pool[$urandom() % pool.size()];
         case ($urandom() % 6)
            0: issue(memWord(memBusPkg::flagRead, 20'(addr)), '0);
            1: issue(memWord(memBusPkg::flagWrite, 20'(addr)), randWord());
            2: issue(memWord(memBusPkg::flagWrTest, 20'(addr)), randWord());
            3: issue(ioWord(memBusPkg::flagRead, 4'd0, memStatPkg::statIoAddr), '0);
            4: issue(ioWord(memBusPkg::flagWrite, 4'd0, memStatPkg::statIoAddr), randWord());
            default: issue(memWord(memBusPkg::flagRead, 20'(32768 + addr)), '0);
         endcase
      end
      randEn = 1'b0;
      drain();

      // Reset in flight
      issue(memWord(memBusPkg::flagRead, 20'(pool[1])), '0);
      idle(1);
      resetPulse();
      issue(ioWord(memBusPkg::flagRead, 4'd0, memStatPkg::statIoAddr), '0);
      drain();

      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      repeat (20 * totalReqs + 2000) @(posedge clk);
      $display("Watchdog expired before the test sequence finished");
      $display("Something failed");
      $finish;
   end

endmodule

//--- tb.f
src/memBusPkg.sv
src/memStatPkg.sv
src/memBusDecode.sv
src/memStatusReg.sv
src/memArray.sv
src/memAccessPipe.sv
src/mem.sv
dv/tbClock.sv
dv/memTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module memTb -o memSim
if [ $? -ne 0 ]; then
   echo "Compile failed"
   exit 1
fi

simOut="$(./obj_dir/memSim)"
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "Everything OK" <<< "$simOut"; then
   exit 0
fi
exit 1
